//--- Bender.yml
package:
  name: tetris

sources:
  - tetris_grid_pkg.sv
  - tetris_ctrl_pkg.sv
  - piece_gen.sv
  - piece_mover.sv
  - grid_store.sv
  - game_fsm.sv
  - tetris_top.sv
  - target: test
    files:
      - tetris_assertions.sv
      - tetris_tb.sv

//--- game_fsm.sv
`default_nettype none

module game_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  tetris_ctrl_pkg::player_cmd_t  cmd,
    input  logic                          landed,
    input  logic                          spawn_blocked,
    input  logic                          clear_done,
    output logic                          spawn,
    output logic                          lock,
    output logic                          clear_start,
    output logic                          wipe,
    output logic                          move_left,
    output logic                          move_right,
    output logic                          move_down,
    output tetris_ctrl_pkg::game_state_t  state
);

    import tetris_ctrl_pkg::*;

    game_state_t next_state;
    logic        fall_live;  // Player strobes accepted this cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ST_SPAWN;
            clear_start <= 1'b0;
        end else begin
            state       <= next_state;
            clear_start <= (state == ST_LOCK) && !cmd.new_game;  // First ST_CLEAR cycle
        end
    end

    always_comb begin
        next_state = state;
        if (cmd.new_game) begin
            next_state = ST_SPAWN;  // Restart from anywhere
        end else begin
            case (state)
                ST_SPAWN: next_state = ST_FALL;
                ST_FALL: begin
                    if (spawn_blocked) begin
                        next_state = ST_OVER;
                    end else if (landed) begin
                        next_state = ST_LOCK;
                    end
                end
                ST_LOCK:  next_state = ST_CLEAR;
                ST_CLEAR: if (clear_done) next_state = ST_SPAWN;
                ST_OVER:  next_state = ST_OVER;   // Hold until new game
                default:  next_state = ST_SPAWN;
            endcase
        end
    end

    assign wipe  = cmd.new_game;
    assign spawn = (state == ST_SPAWN) && !cmd.new_game;
    assign lock  = (state == ST_LOCK) && !cmd.new_game;

    // No moves while the piece is dead or already landed
    assign fall_live = (state == ST_FALL) && !spawn_blocked && !landed && !cmd.new_game;

    // Tick beats left, left beats right
    assign move_down  = fall_live && cmd.tick;
    assign move_left  = fall_live && !cmd.tick && cmd.left;
    assign move_right = fall_live && !cmd.tick && !cmd.left && cmd.right;

endmodule

`default_nettype wire

//--- grid_store.sv
`default_nettype none

module grid_store (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       lock,
    input  logic                       clear_start,
    input  logic                       wipe,
    input  tetris_grid_pkg::grid_t     active,
    input  tetris_grid_pkg::row_idx_t  row_sel,
    output tetris_grid_pkg::grid_t     stored,
    output logic                       clear_done,
    output tetris_ctrl_pkg::line_cnt_t lines,
    output tetris_grid_pkg::row_t      row_data
);

    import tetris_grid_pkg::*;
    import tetris_ctrl_pkg::*;

    logic     scanning;  // Clear scan in progress
    row_idx_t scan_row;  // Row under test, walks upward
    logic     row_full;

    assign row_full   = &stored[scan_row];
    // Done once row 0 has been checked and kept
    assign clear_done = scanning && !row_full && (scan_row == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stored   <= '0;
            scanning <= 1'b0;
            scan_row <= '0;
            lines    <= '0;
        end else if (wipe) begin
            stored   <= '0;  // New game, empty board
            scanning <= 1'b0;
            scan_row <= '0;
            lines    <= '0;
        end else if (lock) begin
            stored <= stored | active;  // Merge landed piece
        end else if (clear_start) begin
            scanning <= 1'b1;
            scan_row <= row_idx_t'(GRID_ROWS - 1);  // Start at the bottom
        end else if (scanning) begin
            if (row_full) begin
                // Drop everything above, same row scanned again
                for (int r = GRID_ROWS - 1; r > 0; r--) begin
                    if (r <= scan_row) begin
                        stored[r] <= stored[r-1];
                    end
                end
                stored[0] <= '0;  // Empty row enters at the top
                lines     <= lines + 1'b1;
            end else if (scan_row == '0) begin
                scanning <= 1'b0;
            end else begin
                scan_row <= scan_row - 1'b1;
            end
        end
    end

    // Display read, settled cells plus moving piece
    always_comb begin
        if (row_sel < GRID_ROWS) begin
            row_data = stored[row_sel] | active[row_sel];
        end else begin
            row_data = '0;  // Off the board
        end
    end

endmodule

`default_nettype wire

//--- piece_gen.sv
`default_nettype none

module piece_gen (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          spawn,
    input  logic                          wipe,
    output tetris_grid_pkg::piece_kind_t  kind,
    output tetris_grid_pkg::grid_t        spawn_mask
);

    import tetris_grid_pkg::*;

    logic last_kind;  // At Z, wrap to I next

    assign last_kind = (kind == piece_kind_t'(NUM_KINDS - 1));

    // Rotating kind register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            kind <= '0;
        end else if (wipe) begin
            kind <= '0;  // New game starts from I again
        end else if (spawn) begin
            if (last_kind) begin
                kind <= '0;
            end else begin
                kind <= kind + 1'b1;
            end
        end
    end

    // Place current shape in rows 0 and 1
    always_comb begin
        spawn_mask    = '0;               // Rest of the board empty
        spawn_mask[0] = SHAPE_TOP[kind];  // Top row of shape
        spawn_mask[1] = SHAPE_BOT[kind];
    end

endmodule

`default_nettype wire

//--- piece_mover.sv
`default_nettype none

module piece_mover (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    spawn,
    input  tetris_grid_pkg::grid_t  spawn_mask,
    input  tetris_grid_pkg::grid_t  stored,
    input  logic                    move_left,
    input  logic                    move_right,
    input  logic                    move_down,
    output tetris_grid_pkg::grid_t  active,
    output logic                    landed,
    output logic                    spawn_blocked
);

    import tetris_grid_pkg::*;

    grid_t left_mask;     // Candidate one column left
    grid_t right_mask;    // Candidate one column right
    grid_t down_mask;     // Candidate one row down
    logic  wall_l;
    logic  wall_r;
    logic  left_blk;
    logic  right_blk;
    logic  down_blk;
    logic  lock_pending;  // Piece waits for the merge cycle

    // Per-row shifts, wall hits
    always_comb begin
        wall_l = 1'b0;
        wall_r = 1'b0;
        for (int r = 0; r < GRID_ROWS; r++) begin
            left_mask[r]  = active[r] << 1;
            right_mask[r] = active[r] >> 1;
            wall_l        = wall_l | active[r][GRID_COLS-1];
            wall_r        = wall_r | active[r][0];
        end
    end

    // Row r moves to r + 1, so the whole vector shifts by one row
    assign down_mask = active << GRID_COLS;

    assign left_blk  = wall_l || (|(left_mask & stored));
    assign right_blk = wall_r || (|(right_mask & stored));
    assign down_blk  = (|active[GRID_ROWS-1]) || (|(down_mask & stored));  // Floor or stack

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active        <= '0;
            landed        <= 1'b0;
            spawn_blocked <= 1'b0;
            lock_pending  <= 1'b0;
        end else begin
            landed        <= move_down && down_blk;            // One cycle after blocked tick
            spawn_blocked <= spawn && (|(spawn_mask & stored)); // New piece overlaps stack
            lock_pending  <= landed;                           // High during the lock cycle

            if (spawn) begin
                active <= spawn_mask;
            end else if (spawn_blocked || lock_pending) begin
                active <= '0;  // Game over, or piece now merged
            end else if (move_down) begin
                if (!down_blk) begin
                    active <= down_mask;
                end
            end else if (move_left) begin
                if (!left_blk) begin
                    active <= left_mask;
                end
            end else if (move_right && !right_blk) begin
                active <= right_mask;
            end
        end
    end

endmodule

`default_nettype wire

//--- src.f
tetris_grid_pkg.sv
tetris_ctrl_pkg.sv
piece_gen.sv
piece_mover.sv
grid_store.sv
game_fsm.sv
tetris_top.sv
tetris_assertions.sv
tetris_tb.sv

//--- tetris_assertions.sv
`default_nettype none

module tetris_assertions (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          spawn,
    input  logic                          spawn_blocked,
    input  tetris_ctrl_pkg::game_state_t  state,
    input  tetris_ctrl_pkg::player_cmd_t  cmd,
    input  tetris_grid_pkg::grid_t        active,
    input  tetris_grid_pkg::grid_t        stored
);

    import tetris_ctrl_pkg::*;

    // Moving piece never sits on settled cells
    // The blocked spawn cycle is the one allowed overlap
    property no_overlap_p;
        @(posedge clk) disable iff (reset)
            (state == ST_FALL && !spawn_blocked) |-> ((active & stored) == '0);
    endproperty

    property spawn_pulse_p;
        @(posedge clk) disable iff (reset)
            spawn |=> !spawn;  // One cycle only
    endproperty

    // Game over is sticky until a new game
    property over_hold_p;
        @(posedge clk) disable iff (reset)
            (state == ST_OVER && !cmd.new_game) |=> (state == ST_OVER);
    endproperty

    a_no_overlap: assert property (no_overlap_p) else $error("active piece overlaps stored grid");
    a_spawn_pulse: assert property (spawn_pulse_p) else $error("spawn held longer than one cycle");
    a_over_hold: assert property (over_hold_p) else $error("left game over without new game");

endmodule

`default_nettype wire

//--- tetris_ctrl_pkg.sv
`default_nettype none

package tetris_ctrl_pkg;

    // Game control FSM states
    typedef enum logic [2:0] {
        ST_SPAWN,  // Load the next piece
        ST_FALL,   // Piece under player control
        ST_LOCK,   // Merge piece into grid
        ST_CLEAR,  // Row clear scan running
        ST_OVER    // Wait for new game
    } game_state_t;

    typedef logic [15:0] line_cnt_t;  // Cleared line count

    // Player strobes, one cycle each
    typedef struct packed {
        logic left;
        logic right;
        logic tick;      // Gravity step
        logic new_game;
    } player_cmd_t;

    // Host-visible status
    typedef struct packed {
        game_state_t                 state;
        tetris_grid_pkg::piece_kind_t kind;
        logic                        game_over;
        line_cnt_t                   lines;
    } game_status_t;

endpackage

`default_nettype wire

//--- tetris_grid_pkg.sv
`default_nettype none

package tetris_grid_pkg;

    // Board geometry
    localparam int GRID_ROWS = 22;  // Row 0 at the top
    localparam int GRID_COLS = 10;  // Bit 9 is the leftmost column
    localparam int NUM_KINDS = 7;

    typedef logic [GRID_COLS-1:0] row_t;       // One board row
    typedef row_t [GRID_ROWS-1:0] grid_t;      // Whole board, row r at index r
    typedef logic [4:0]           row_idx_t;   // Row number
    typedef logic [2:0]           piece_kind_t;  // I, O, T, L, J, S, Z

    // Spawn shapes, two rows each, centred on columns 3 to 6
    localparam row_t SHAPE_TOP [NUM_KINDS] = '{
        10'b0001111000,  // I
        10'b0000110000,  // O
        10'b0001110000,  // T
        10'b0001110000,  // L
        10'b0001110000,  // J
        10'b0000110000,  // S
        10'b0001100000   // Z
    };

    localparam row_t SHAPE_BOT [NUM_KINDS] = '{
        10'b0000000000,  // I is flat, one row only
        10'b0000110000,  // O
        10'b0000100000,  // T stem
        10'b0001000000,  // L foot on the left
        10'b0000010000,  // J foot on the right
        10'b0001100000,  // S
        10'b0000110000   // Z
    };

endpackage

`default_nettype wire

//--- tetris_tb.sv
`default_nettype none

module tetris_tb;

    import tetris_grid_pkg::*;
    import tetris_ctrl_pkg::*;

    localparam int SETTLE_LIMIT = 200;  // Cycles allowed per settle wait

    logic         clk;
    logic         reset;
    player_cmd_t  cmd;
    row_idx_t     row_sel;
    row_t         row_data;
    game_status_t status;

    int    errors;      // Total mismatches
    int    test_errs;   // Mismatches at start of current test
    int    tests_run;
    int    tests_bad;
    string test_name;
    logic  hung;        // A settle wait ran out, script stops

    tetris_top uut (
        .clk, .reset, .cmd, .row_sel, .row_data, .status
    );

    bind tetris_top tetris_assertions u_assert (
        .clk, .reset, .spawn, .spawn_blocked, .state, .cmd, .active, .stored
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Wait until state rests in FALL or OVER for two samples in a row
    task automatic wait_settled();
        logic [2:0] prev;
        logic [2:0] now;
        int         cycles;
        logic       done;
        prev   = 3'b111;  // Not a legal state
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < SETTLE_LIMIT) begin
            @(negedge clk);
            now = status.state;
            if ((now == ST_FALL || now == ST_OVER) && now == prev) begin
                done = 1'b1;
            end
            prev = now;
            cycles++;
        end
        if (!done) begin
            $display("Timeout: game never settled in test %s, state stuck at %0d", test_name, now);
            errors++;
            hung = 1'b1;
        end
    endtask

    // n strobes, each one cycle wide, settle after each
    task automatic pulse_cmd(input player_cmd_t c, input int n);
        for (int i = 0; i < n && !hung; i++) begin
            @(negedge clk);
            cmd = c;
            @(negedge clk);
            cmd = '0;
            wait_settled();
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        cmd   = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        wait_settled();
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (errors == test_errs) begin
                $display("PASS %s", test_name);
            end else begin
                tests_bad++;
                $display("FAIL %s with %0d mismatches", test_name, errors - test_errs);
            end
        end
    endtask

    task automatic run_script(input int fd);
        string       line;
        string       op;
        string       word;
        int          rc;
        int          a;
        int          b;
        int          c;
        player_cmd_t pc;
        while (!$feof(fd) && !hung) begin
            line = "";
            rc   = $fgets(line, fd);
            op   = "";
            if (rc > 0 && line.len() > 1 && line[0] != "#") begin
                rc = $sscanf(line, "%s", op);
            end
            pc = '0;
            case (op)
                "test": begin
                    close_test();
                    rc        = $sscanf(line, "%s %s", op, word);
                    test_name = word;
                    test_errs = errors;
                end
                "reset": apply_reset();
                "newgame": begin
                    pc.new_game = 1'b1;
                    pulse_cmd(pc, 1);
                end
                "left", "right", "tick": begin
                    rc       = $sscanf(line, "%s %d", op, a);
                    pc.left  = (op == "left");
                    pc.right = (op == "right");
                    pc.tick  = (op == "tick");
                    pulse_cmd(pc, a);
                end
                "row": begin
                    rc = $sscanf(line, "%s %d %h", op, a, b);
                    @(negedge clk);
                    row_sel = row_idx_t'(a);
                    #10;  // Combinational read settles
                    check_eq(32'(row_data), b, $sformatf("row %0d", a));
                end
                "status": begin
                    rc = $sscanf(line, "%s %d %d %d", op, a, b, c);
                    check_eq(32'(status.kind), a, "kind");
                    check_eq(32'(status.lines), b, "lines");
                    check_eq(32'(status.game_over), c, "game_over");
                    // Settled game sits in OVER when game over, else in FALL
                    check_eq(32'(status.state), (c != 0) ? 32'(ST_OVER) : 32'(ST_FALL),
                             "state");
                end
                "": ;  // Blank or comment line
                default: begin
                    $display("Unknown command in test data: %s", op);
                    errors++;
                end
            endcase
        end
    endtask

    initial begin
        int fd;
        reset     = 1'b1;
        cmd       = '0;
        row_sel   = '0;
        errors    = 0;
        test_errs = 0;
        tests_run = 0;
        tests_bad = 0;
        test_name = "";
        hung      = 1'b0;
        fd = $fopen("tetris_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open tetris_testdata.txt");
            $display("tests failed");
            $finish;
        end else begin
            run_script(fd);
            $fclose(fd);
            close_test();
            $display("Summary: %0d tests run, %0d bad, %0d mismatches",
                     tests_run, tests_bad, errors);
            if (errors == 0 && tests_bad == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tetris_testdata.txt
# command [args]: test NAME | reset | newgame | left/right/tick COUNT
# row ROW HEXVALUE | status KIND LINES GAME_OVER (checked once state settles)
test reset_spawn
reset
status 1 0 0
row 0 078
row 1 000
row 21 000
test walls
left 5
row 0 3c0
right 10
row 0 00f
test drop_lock
tick 22
row 21 00f
row 20 000
row 0 030
row 1 030
status 2 0 0
test line_clear
newgame
status 1 0 0
row 21 000
right 3
tick 22
tick 21
row 21 03f
row 20 030
right 3
tick 20
right 2
tick 19
right 2
tick 17
right 4
tick 15
right 1
tick 15
left 3
tick 22
row 21 034
row 20 01e
row 19 01c
row 18 004
row 17 01c
row 16 01e
row 15 033
row 14 000
row 0 030
status 2 1 0
test game_over
newgame
status 1 0 0
tick 140
status 6 0 1
row 0 070
row 1 010
row 3 040
row 21 078
left 3
right 2
status 6 0 1
row 0 070
newgame
status 1 0 0
row 0 078
row 21 000

//--- tetris_top.sv
`default_nettype none

module tetris_top (
    input  logic                          clk,
    input  logic                          reset,
    input  tetris_ctrl_pkg::player_cmd_t  cmd,
    input  tetris_grid_pkg::row_idx_t     row_sel,
    output tetris_grid_pkg::row_t         row_data,
    output tetris_ctrl_pkg::game_status_t status
);

    import tetris_grid_pkg::*;
    import tetris_ctrl_pkg::*;

    logic        spawn, lock, clear_start, wipe;  // FSM strobes
    logic        move_left, move_right, move_down;
    logic        landed, spawn_blocked, clear_done;
    game_state_t state;
    piece_kind_t kind;
    grid_t       spawn_mask, active, stored;
    line_cnt_t   lines;

    game_fsm u_fsm (
        .clk, .reset, .cmd, .landed, .spawn_blocked, .clear_done,
        .spawn, .lock, .clear_start, .wipe,
        .move_left, .move_right, .move_down, .state
    );

    piece_gen u_gen (.clk, .reset, .spawn, .wipe, .kind, .spawn_mask);

    piece_mover u_mover (
        .clk, .reset, .spawn, .spawn_mask, .stored,
        .move_left, .move_right, .move_down,
        .active, .landed, .spawn_blocked
    );

    grid_store u_grid (
        .clk, .reset, .lock, .clear_start, .wipe, .active, .row_sel,
        .stored, .clear_done, .lines, .row_data
    );

    assign status = '{state: state, kind: kind, game_over: (state == ST_OVER), lines: lines};

endmodule

`default_nettype wire
